// ==== axi_config.svh ====
`ifndef AXI_CONFIG_SVH
`define AXI_CONFIG_SVH

// bus widths shared by the full AXI and AXI-Lite sides
`define AXI_ADDR_WIDTH 20
`define AXI_DATA_WIDTH 16
`define AXI_ID_WIDTH 4

// one strobe bit per data byte
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)

`endif

// ==== axi_pkg.sv ====
`include "axi_config.svh"

package axi_pkg;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  // encoding order is also the severity order
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // shared by AW and AR
  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                 len;
    logic [2:0]                 size;
    burst_e                     burst;
  } ax_t;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_STRB_WIDTH-1:0] strb;
    logic                       last;
  } w_t;

  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0] id;
    resp_e                    resp;
  } b_t;

  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_DATA_WIDTH-1:0] data;
    resp_e                      resp;
    logic                       last;
  } r_t;

endpackage

// ==== axil_pkg.sv ====
`include "axi_config.svh"

package axil_pkg;

  // AW and AR carry only the address on the lite side
  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0] addr;
  } a_t;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_STRB_WIDTH-1:0] strb;
  } w_t;

  // response codes are the same as on full AXI
  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    axi_pkg::resp_e             resp;
  } r_t;

endpackage

// ==== burst_addr_gen.sv ====
`timescale 1ns/1ps
`include "axi_config.svh"

module burst_addr_gen (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       load,
  input  logic                       step,
  input  axi_pkg::ax_t               ax,
  output logic [`AXI_ADDR_WIDTH-1:0] addr
);

  localparam int AW = `AXI_ADDR_WIDTH;

  logic [AW-1:0]   addr_q;
  logic [7:0]      len_q;
  logic [2:0]      size_q;
  axi_pkg::burst_e burst_q;
  logic [AW-1:0]   stride;
  logic [AW-1:0]   incr_addr;
  logic [AW-1:0]   wrap_mask;
  logic [AW-1:0]   next_addr;

  assign stride    = AW'(1) << size_q;
  assign incr_addr = addr_q + stride;

  // wrap window is (len+1) strides and is aligned to its own size
  assign wrap_mask = ((AW'(len_q) + AW'(1)) << size_q) - AW'(1);

  always_comb begin
    case (burst_q)
      axi_pkg::FIXED: next_addr = addr_q;
      axi_pkg::WRAP:  next_addr = (addr_q & ~wrap_mask) | (incr_addr & wrap_mask);
      default:        next_addr = incr_addr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_q  <= '0;
      len_q   <= '0;
      size_q  <= '0;
      burst_q <= axi_pkg::INCR;
    end else if (load) begin
      addr_q  <= ax.addr;
      len_q   <= ax.len;
      size_q  <= ax.size;
      burst_q <= ax.burst;
    end else if (step) begin
      addr_q <= next_addr;
    end
  end

  assign addr = addr_q;

endmodule

// ==== resp_merge.sv ====
`timescale 1ns/1ps
`include "axi_config.svh"

module resp_merge (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     clear,
  input  logic                     fold,
  input  logic [`AXI_ID_WIDTH-1:0] id,
  input  axi_pkg::resp_e           resp,
  output axi_pkg::b_t              b
);

  logic [`AXI_ID_WIDTH-1:0] id_q;
  axi_pkg::resp_e           resp_q;

  always_ff @(posedge clk) begin
    if (clear) begin
      id_q <= id;
    end
  end

  // higher code is the more severe response
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_q <= axi_pkg::OKAY;
    end else if (clear) begin
      resp_q <= axi_pkg::OKAY;
    end else if (fold && (resp > resp_q)) begin
      resp_q <= resp;
    end
  end

  assign b.id   = id_q;
  assign b.resp = resp_q;

endmodule

// ==== burst_ctrl.sv ====
`timescale 1ns/1ps
`include "axi_config.svh"

module burst_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  axi_pkg::ax_t             s_aw,
  input  logic                     s_awvalid,
  output logic                     s_awready,
  input  logic                     s_wvalid,
  output logic                     s_wready,
  output logic                     s_bvalid,
  input  logic                     s_bready,
  input  axi_pkg::ax_t             s_ar,
  input  logic                     s_arvalid,
  output logic                     s_arready,
  output logic                     s_rvalid,
  input  logic                     s_rready,
  output logic                     m_awvalid,
  input  logic                     m_awready,
  output logic                     m_wvalid,
  input  logic                     m_wready,
  input  logic                     m_bvalid,
  output logic                     m_bready,
  output logic                     m_arvalid,
  input  logic                     m_arready,
  input  logic                     m_rvalid,
  output logic                     m_rready,
  output logic                     wr_load,
  output logic                     wr_step,
  output logic                     rd_load,
  output logic                     rd_step,
  output logic                     resp_clear,
  output logic                     resp_fold,
  output logic [`AXI_ID_WIDTH-1:0] rd_id,
  output logic                     rd_last
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ISSUE,
    WR_RESP_WAIT,
    WR_RESPOND
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ISSUE,
    RD_WAIT
  } rd_state_e;

  wr_state_e                wr_state;
  rd_state_e                rd_state;
  logic [7:0]               wr_len;
  logic [7:0]               wr_cnt;
  logic [7:0]               rd_len;
  logic [7:0]               rd_cnt;
  logic [`AXI_ID_WIDTH-1:0] rd_id_q;
  logic                     aw_done;
  logic                     w_done;
  logic                     aw_ok;
  logic                     w_ok;
  logic                     b_fire;
  logic                     r_fire;

  // write side
  assign s_awready  = (wr_state == WR_IDLE);
  assign wr_load    = s_awvalid && s_awready;
  assign resp_clear = wr_load;

  // both lite channels follow the AXI W beat and each drops once taken
  assign m_awvalid = (wr_state == WR_ISSUE) && s_wvalid && !aw_done;
  assign m_wvalid  = (wr_state == WR_ISSUE) && s_wvalid && !w_done;
  assign aw_ok     = aw_done || (m_awvalid && m_awready);
  assign w_ok      = w_done || (m_wvalid && m_wready);
  assign s_wready  = (wr_state == WR_ISSUE) && s_wvalid && aw_ok && w_ok;

  assign m_bready  = (wr_state == WR_RESP_WAIT);
  assign b_fire    = m_bvalid && m_bready;
  assign resp_fold = b_fire;
  assign wr_step   = b_fire;
  assign s_bvalid  = (wr_state == WR_RESPOND);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_state <= WR_IDLE;
      wr_len   <= '0;
      wr_cnt   <= '0;
      aw_done  <= 1'b0;
      w_done   <= 1'b0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (wr_load) begin
            wr_len   <= s_aw.len;
            wr_cnt   <= '0;
            wr_state <= WR_ISSUE;
          end
        end
        WR_ISSUE: begin
          if (s_wready) begin
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            wr_state <= WR_RESP_WAIT;
          end else begin
            aw_done <= aw_ok;
            w_done  <= w_ok;
          end
        end
        WR_RESP_WAIT: begin
          if (b_fire) begin
            if (wr_cnt == wr_len) begin
              wr_state <= WR_RESPOND;
            end else begin
              wr_cnt   <= wr_cnt + 8'd1;
              wr_state <= WR_ISSUE;
            end
          end
        end
        default: begin
          if (s_bready) begin
            wr_state <= WR_IDLE;
          end
        end
      endcase
    end
  end

  // read side keeps one lite read outstanding at a time
  assign s_arready = (rd_state == RD_IDLE);
  assign rd_load   = s_arvalid && s_arready;
  assign m_arvalid = (rd_state == RD_ISSUE);
  assign m_rready  = (rd_state == RD_WAIT) && s_rready;
  assign s_rvalid  = (rd_state == RD_WAIT) && m_rvalid;
  assign r_fire    = s_rvalid && s_rready;
  assign rd_step   = r_fire;
  assign rd_id     = rd_id_q;
  assign rd_last   = (rd_cnt == rd_len);

  always_ff @(posedge clk) begin
    if (rd_load) begin
      rd_id_q <= s_ar.id;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_state <= RD_IDLE;
      rd_len   <= '0;
      rd_cnt   <= '0;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (rd_load) begin
            rd_len   <= s_ar.len;
            rd_cnt   <= '0;
            rd_state <= RD_ISSUE;
          end
        end
        RD_ISSUE: begin
          if (m_arready) begin
            rd_state <= RD_WAIT;
          end
        end
        default: begin
          if (r_fire) begin
            if (rd_last) begin
              rd_state <= RD_IDLE;
            end else begin
              rd_cnt   <= rd_cnt + 8'd1;
              rd_state <= RD_ISSUE;
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== axi_axil_adapter.sv ====
`timescale 1ns/1ps
`include "axi_config.svh"

module axi_axil_adapter (
  input  logic           clk,
  input  logic           rst_n,
  input  axi_pkg::ax_t   s_aw,
  input  logic           s_awvalid,
  output logic           s_awready,
  input  axi_pkg::w_t    s_w,
  input  logic           s_wvalid,
  output logic           s_wready,
  output axi_pkg::b_t    s_b,
  output logic           s_bvalid,
  input  logic           s_bready,
  input  axi_pkg::ax_t   s_ar,
  input  logic           s_arvalid,
  output logic           s_arready,
  output axi_pkg::r_t    s_r,
  output logic           s_rvalid,
  input  logic           s_rready,
  output axil_pkg::a_t   m_aw,
  output logic           m_awvalid,
  input  logic           m_awready,
  output axil_pkg::w_t   m_w,
  output logic           m_wvalid,
  input  logic           m_wready,
  input  axi_pkg::resp_e m_bresp,
  input  logic           m_bvalid,
  output logic           m_bready,
  output axil_pkg::a_t   m_ar,
  output logic           m_arvalid,
  input  logic           m_arready,
  input  axil_pkg::r_t   m_r,
  input  logic           m_rvalid,
  output logic           m_rready
);

  logic                       wr_load;
  logic                       wr_step;
  logic                       rd_load;
  logic                       rd_step;
  logic                       resp_clear;
  logic                       resp_fold;
  logic [`AXI_ID_WIDTH-1:0]   rd_id;
  logic                       rd_last;
  logic [`AXI_ADDR_WIDTH-1:0] wr_addr;
  logic [`AXI_ADDR_WIDTH-1:0] rd_addr;

  // lite payloads
  assign m_aw.addr = wr_addr;
  assign m_ar.addr = rd_addr;
  assign m_w.data  = s_w.data;
  assign m_w.strb  = s_w.strb;

  // read beats pass through with the stored id
  assign s_r.id   = rd_id;
  assign s_r.data = m_r.data;
  assign s_r.resp = m_r.resp;
  assign s_r.last = rd_last;

  burst_ctrl burst_ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_aw      (s_aw),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_ar      (s_ar),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .m_wvalid  (m_wvalid),
    .m_wready  (m_wready),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),
    .m_arvalid (m_arvalid),
    .m_arready (m_arready),
    .m_rvalid  (m_rvalid),
    .m_rready  (m_rready),
    .wr_load   (wr_load),
    .wr_step   (wr_step),
    .rd_load   (rd_load),
    .rd_step   (rd_step),
    .resp_clear(resp_clear),
    .resp_fold (resp_fold),
    .rd_id     (rd_id),
    .rd_last   (rd_last)
  );

  burst_addr_gen wr_addr_i (
    .clk  (clk),
    .rst_n(rst_n),
    .load (wr_load),
    .step (wr_step),
    .ax   (s_aw),
    .addr (wr_addr)
  );

  burst_addr_gen rd_addr_i (
    .clk  (clk),
    .rst_n(rst_n),
    .load (rd_load),
    .step (rd_step),
    .ax   (s_ar),
    .addr (rd_addr)
  );

  resp_merge resp_merge_i (
    .clk  (clk),
    .rst_n(rst_n),
    .clear(resp_clear),
    .fold (resp_fold),
    .id   (s_aw.id),
    .resp (m_bresp),
    .b    (s_b)
  );

endmodule

// ==== axi_axil_adapter_asserts.sv ====
`timescale 1ns/1ps
`include "axi_config.svh"

module axi_axil_adapter_asserts (
  input logic         clk,
  input logic         rst_n,
  input axil_pkg::a_t m_aw,
  input logic         m_awvalid,
  input logic         m_awready,
  input axil_pkg::w_t m_w,
  input logic         m_wvalid,
  input logic         m_wready,
  input axil_pkg::a_t m_ar,
  input logic         m_arvalid,
  input logic         m_arready,
  input logic         m_bvalid,
  input logic         m_bready,
  input logic         s_bvalid
);

  int         assert_fails = 0;
  logic [8:0] outstanding;

  // lite writes issued but not yet answered
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + 9'(m_awvalid && m_awready) - 9'(m_bvalid && m_bready);
    end
  end

  aw_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_awvalid && !m_awready |=> m_awvalid)
    else begin
      $error("m_awvalid dropped before m_awready");
      assert_fails++;
    end

  w_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_wvalid && !m_wready |=> m_wvalid)
    else begin
      $error("m_wvalid dropped before m_wready");
      assert_fails++;
    end

  ar_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_arvalid && !m_arready |=> m_arvalid)
    else begin
      $error("m_arvalid dropped before m_arready");
      assert_fails++;
    end

  aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
    m_awvalid && !m_awready |=> $stable(m_aw))
    else begin
      $error("m_aw changed while stalled");
      assert_fails++;
    end

  w_stable: assert property (@(posedge clk) disable iff (!rst_n)
    m_wvalid && !m_wready |=> $stable(m_w))
    else begin
      $error("m_w changed while stalled");
      assert_fails++;
    end

  ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    m_arvalid && !m_arready |=> $stable(m_ar))
    else begin
      $error("m_ar changed while stalled");
      assert_fails++;
    end

  b_after_lite_done: assert property (@(posedge clk) disable iff (!rst_n)
    s_bvalid |-> (outstanding == '0))
    else begin
      $error("s_bvalid high with a lite write outstanding");
      assert_fails++;
    end

endmodule

bind axi_axil_adapter axi_axil_adapter_asserts asserts_i (.*);

// ==== axi_axil_adapter_tb.sv ====
`timescale 1ns/1ps
`include "axi_config.svh"

module axi_axil_adapter_tb;

  localparam int AW = `AXI_ADDR_WIDTH;
  localparam int DW = `AXI_DATA_WIDTH;
  localparam int SW = `AXI_STRB_WIDTH;
  localparam int TIMEOUT = 200;

  logic           clk;
  logic           rst_n;
  axi_pkg::ax_t   s_aw;
  logic           s_awvalid;
  logic           s_awready;
  axi_pkg::w_t    s_w;
  logic           s_wvalid;
  logic           s_wready;
  axi_pkg::b_t    s_b;
  logic           s_bvalid;
  logic           s_bready;
  axi_pkg::ax_t   s_ar;
  logic           s_arvalid;
  logic           s_arready;
  axi_pkg::r_t    s_r;
  logic           s_rvalid;
  logic           s_rready;
  axil_pkg::a_t   m_aw;
  logic           m_awvalid;
  logic           m_awready;
  axil_pkg::w_t   m_w;
  logic           m_wvalid;
  logic           m_wready;
  axi_pkg::resp_e m_bresp;
  logic           m_bvalid;
  logic           m_bready;
  axil_pkg::a_t   m_ar;
  logic           m_arvalid;
  logic           m_arready;
  axil_pkg::r_t   m_r;
  logic           m_rvalid;
  logic           m_rready;

  // lite memory model
  logic [DW-1:0]  mem [logic [AW-1:0]];
  axi_pkg::resp_e inject [logic [AW-1:0]];
  axil_pkg::a_t   aw_log[$];
  axil_pkg::w_t   w_log[$];
  axil_pkg::a_t   ar_log[$];
  axil_pkg::a_t   aw_pend[$];
  axil_pkg::w_t   w_pend[$];
  axi_pkg::resp_e b_pend[$];
  axil_pkg::r_t   r_pend[$];
  logic           stall_en;

  logic [DW-1:0]  beat_data [256];
  logic [SW-1:0]  beat_strb [256];
  logic [AW-1:0]  exp_addr [256];
  axi_pkg::b_t    b_got;
  axi_pkg::r_t    r_got [256];

  axi_axil_adapter axi_axil_adapter_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [DW-1:0] read_word(input logic [AW-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return DW'(a) ^ DW'(a >> 4) ^ DW'('hC3A5);
  endfunction

  function automatic axi_pkg::resp_e resp_for(input logic [AW-1:0] a);
    if (inject.exists(a)) begin
      return inject[a];
    end
    return axi_pkg::OKAY;
  endfunction

  function automatic axi_pkg::ax_t make_ax(input logic [`AXI_ID_WIDTH-1:0] id,
                                           input logic [AW-1:0] addr, input logic [7:0] len,
                                           input axi_pkg::burst_e burst);
    axi_pkg::ax_t ax;
    ax.id    = id;
    ax.addr  = addr;
    ax.len   = len;
    // a full bus word per beat
    ax.size  = 3'($clog2(SW));
    ax.burst = burst;
    return ax;
  endfunction

  // model sees each handshake in the cycle where it happens
  always @(posedge clk) begin
    axil_pkg::a_t  a_tmp;
    axil_pkg::w_t  w_tmp;
    axil_pkg::r_t  r_tmp;
    logic [DW-1:0] word;
    if (m_awvalid && m_awready) begin
      aw_log.push_back(m_aw);
      aw_pend.push_back(m_aw);
    end
    if (m_wvalid && m_wready) begin
      w_log.push_back(m_w);
      w_pend.push_back(m_w);
    end
    if (aw_pend.size() != 0 && w_pend.size() != 0) begin
      a_tmp = aw_pend.pop_front();
      w_tmp = w_pend.pop_front();
      word  = read_word(a_tmp.addr);
      for (int i = 0; i < SW; i++) begin
        if (w_tmp.strb[i]) begin
          word[i*8 +: 8] = w_tmp.data[i*8 +: 8];
        end
      end
      mem[a_tmp.addr] = word;
      b_pend.push_back(resp_for(a_tmp.addr));
    end
    if (m_bvalid && m_bready) begin
      b_pend.delete(0);
    end
    if (m_arvalid && m_arready) begin
      ar_log.push_back(m_ar);
      r_tmp.data = read_word(m_ar.addr);
      r_tmp.resp = resp_for(m_ar.addr);
      r_pend.push_back(r_tmp);
    end
    if (m_rvalid && m_rready) begin
      r_pend.delete(0);
    end
  end

  // once raised, a response valid stays up until it is taken
  always @(negedge clk) begin
    m_awready = !stall_en || ($urandom % 2 == 0);
    m_wready  = !stall_en || ($urandom % 2 == 0);
    m_arready = !stall_en || ($urandom % 2 == 0);
    if (b_pend.size() != 0 && (m_bvalid || !stall_en || $urandom % 2 == 0)) begin
      m_bvalid = 1'b1;
      m_bresp  = b_pend[0];
    end else begin
      m_bvalid = 1'b0;
    end
    if (r_pend.size() != 0 && (m_rvalid || !stall_en || $urandom % 2 == 0)) begin
      m_rvalid = 1'b1;
      m_r      = r_pend[0];
    end else begin
      m_rvalid = 1'b0;
    end
  end

  always @(negedge clk) begin
    if (axi_axil_adapter_i.asserts_i.assert_fails != 0) begin
      abort_run("a protocol assertion on the lite port failed");
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR: %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_b(input string name, input axi_pkg::b_t got, input axi_pkg::b_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR: %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_r(input string name, input axi_pkg::r_t got, input axi_pkg::r_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR: %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_lite_addr(input string name, input axil_pkg::a_t got,
                                 input axil_pkg::a_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR: %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_lite_w(input string name, input axil_pkg::w_t got,
                              input axil_pkg::w_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR: %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic send_aw(input axi_pkg::ax_t ax);
    int n;
    @(negedge clk);
    s_aw      = ax;
    s_awvalid = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!s_awready && n < TIMEOUT);
    if (!s_awready) begin
      abort_run("timeout waiting for the write address to be accepted");
    end
    @(negedge clk);
    s_awvalid = 1'b0;
  endtask

  task automatic send_ar(input axi_pkg::ax_t ax);
    int n;
    @(negedge clk);
    s_ar      = ax;
    s_arvalid = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!s_arready && n < TIMEOUT);
    if (!s_arready) begin
      abort_run("timeout waiting for the read address to be accepted");
    end
    @(negedge clk);
    s_arvalid = 1'b0;
  endtask

  task automatic write_burst(input axi_pkg::ax_t ax);
    int n;
    int i;
    send_aw(ax);
    for (i = 0; i <= ax.len; i++) begin
      @(negedge clk);
      s_w.data = beat_data[i];
      s_w.strb = beat_strb[i];
      s_w.last = (i == ax.len);
      s_wvalid = 1'b1;
      n = 0;
      do begin
        @(posedge clk);
        n++;
      end while (!s_wready && n < TIMEOUT);
      if (!s_wready) begin
        abort_run("timeout waiting for a write beat to be accepted");
      end
    end
    @(negedge clk);
    s_wvalid = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      s_bready = !stall_en || ($urandom % 2 == 0);
      @(posedge clk);
      n++;
    end while (!(s_bvalid && s_bready) && n < TIMEOUT);
    if (!(s_bvalid && s_bready)) begin
      abort_run("timeout waiting for the write response");
    end
    b_got = s_b;
    @(negedge clk);
    s_bready = 1'b0;
    // a burst gets exactly one B
    repeat (4) begin
      @(posedge clk);
      check_bit("s_bvalid", s_bvalid, 1'b0);
    end
  endtask

  task automatic read_burst(input axi_pkg::ax_t ax);
    int n;
    int i;
    send_ar(ax);
    for (i = 0; i <= ax.len; i++) begin
      n = 0;
      do begin
        @(negedge clk);
        s_rready = !stall_en || ($urandom % 2 == 0);
        @(posedge clk);
        n++;
      end while (!(s_rvalid && s_rready) && n < TIMEOUT);
      if (!(s_rvalid && s_rready)) begin
        abort_run("timeout waiting for a read beat");
      end
      r_got[i] = s_r;
    end
    @(negedge clk);
    s_rready = 1'b0;
  endtask

  task automatic compare_write_log(input int n);
    axil_pkg::a_t exp_a;
    axil_pkg::w_t exp_w;
    int           i;
    if (aw_log.size() != n || w_log.size() != n) begin
      abort_run($sformatf("expected %0d lite writes but saw %0d addresses and %0d data beats",
                          n, aw_log.size(), w_log.size()));
    end
    for (i = 0; i < n; i++) begin
      exp_a.addr = exp_addr[i];
      check_lite_addr($sformatf("m_aw[%0d]", i), aw_log[i], exp_a);
      exp_w.data = beat_data[i];
      exp_w.strb = beat_strb[i];
      check_lite_w($sformatf("m_w[%0d]", i), w_log[i], exp_w);
    end
    aw_log.delete();
    w_log.delete();
  endtask

  task automatic compare_read_beats(input logic [`AXI_ID_WIDTH-1:0] id, input int n);
    axil_pkg::a_t exp_a;
    axi_pkg::r_t  exp_r;
    int           i;
    if (ar_log.size() != n) begin
      abort_run($sformatf("expected %0d lite reads but saw %0d", n, ar_log.size()));
    end
    for (i = 0; i < n; i++) begin
      exp_a.addr = exp_addr[i];
      check_lite_addr($sformatf("m_ar[%0d]", i), ar_log[i], exp_a);
      exp_r.id   = id;
      exp_r.data = beat_data[i];
      exp_r.resp = axi_pkg::OKAY;
      exp_r.last = (i == n - 1);
      check_r($sformatf("s_r[%0d]", i), r_got[i], exp_r);
    end
    ar_log.delete();
  endtask

  task automatic reset_values();
    @(posedge clk);
    check_bit("m_awvalid", m_awvalid, 1'b0);
    check_bit("m_wvalid", m_wvalid, 1'b0);
    check_bit("m_arvalid", m_arvalid, 1'b0);
    check_bit("s_bvalid", s_bvalid, 1'b0);
    check_bit("s_rvalid", s_rvalid, 1'b0);
    check_bit("m_bready", m_bready, 1'b0);
    check_bit("s_wready", s_wready, 1'b0);
    check_bit("s_awready", s_awready, 1'b1);
    check_bit("s_arready", s_arready, 1'b1);
  endtask

  task automatic incr_write_burst();
    axi_pkg::b_t exp_b;
    beat_data[0] = 16'h1234;
    beat_data[1] = 16'h5678;
    beat_data[2] = 16'h9ABC;
    beat_data[3] = 16'hDEF0;
    beat_strb[0] = 2'b11;
    beat_strb[1] = 2'b01;
    beat_strb[2] = 2'b10;
    beat_strb[3] = 2'b11;
    for (int i = 0; i < 4; i++) begin
      exp_addr[i] = 20'hA000 + 2 * i;
    end
    write_burst(make_ax(4'hD, 20'hA000, 8'd3, axi_pkg::INCR));
    compare_write_log(4);
    exp_b.id   = 4'hD;
    exp_b.resp = axi_pkg::OKAY;
    check_b("s_b", b_got, exp_b);
  endtask

  task automatic incr_read_burst();
    for (int i = 0; i < 4; i++) begin
      exp_addr[i]  = 20'hB000 + 2 * i;
      beat_data[i] = 16'hA5C0 + 16'(i * 17);
      mem[exp_addr[i]] = beat_data[i];
    end
    read_burst(make_ax(4'h5, 20'hB000, 8'd3, axi_pkg::INCR));
    compare_read_beats(4'h5, 4);
  endtask

  task automatic wrap_and_fixed_bursts();
    axi_pkg::b_t   exp_b;
    logic [DW-1:0] fixed_word;
    // window of 8 bytes starting mid-window
    exp_addr[0] = 20'h00006;
    exp_addr[1] = 20'h00000;
    exp_addr[2] = 20'h00002;
    exp_addr[3] = 20'h00004;
    for (int i = 0; i < 4; i++) begin
      beat_data[i] = 16'h7000 + 16'(i);
      beat_strb[i] = '1;
    end
    write_burst(make_ax(4'h3, 20'h00006, 8'd3, axi_pkg::WRAP));
    compare_write_log(4);
    exp_b.id   = 4'h3;
    exp_b.resp = axi_pkg::OKAY;
    check_b("s_b", b_got, exp_b);
    fixed_word = beat_data[3];
    for (int i = 0; i < 3; i++) begin
      exp_addr[i]  = 20'h00004;
      beat_data[i] = fixed_word;
    end
    read_burst(make_ax(4'h9, 20'h00004, 8'd2, axi_pkg::FIXED));
    compare_read_beats(4'h9, 3);
  endtask

  task automatic error_resp_merge();
    axi_pkg::b_t exp_b;
    for (int i = 0; i < 4; i++) begin
      exp_addr[i]  = 20'h01000 + 2 * i;
      beat_data[i] = 16'h4400 + 16'(i);
      beat_strb[i] = '1;
    end
    inject[20'h01002] = axi_pkg::SLVERR;
    write_burst(make_ax(4'h1, 20'h01000, 8'd3, axi_pkg::INCR));
    compare_write_log(4);
    exp_b.id   = 4'h1;
    exp_b.resp = axi_pkg::SLVERR;
    check_b("s_b", b_got, exp_b);
    inject.delete();
    for (int i = 0; i < 4; i++) begin
      exp_addr[i] = 20'h02000 + 2 * i;
    end
    inject[20'h02000] = axi_pkg::SLVERR;
    inject[20'h02004] = axi_pkg::DECERR;
    write_burst(make_ax(4'h2, 20'h02000, 8'd3, axi_pkg::INCR));
    compare_write_log(4);
    exp_b.id   = 4'h2;
    exp_b.resp = axi_pkg::DECERR;
    check_b("s_b", b_got, exp_b);
    inject.delete();
  endtask

  task automatic random_stall_traffic();
    axi_pkg::b_t exp_b;
    stall_en = 1'b1;
    for (int i = 0; i < 16; i++) begin
      exp_addr[i]  = 20'h03000 + 2 * i;
      beat_data[i] = DW'($urandom);
      beat_strb[i] = '1;
    end
    write_burst(make_ax(4'h7, 20'h03000, 8'd15, axi_pkg::INCR));
    compare_write_log(16);
    exp_b.id   = 4'h7;
    exp_b.resp = axi_pkg::OKAY;
    check_b("s_b", b_got, exp_b);
    read_burst(make_ax(4'hE, 20'h03000, 8'd15, axi_pkg::INCR));
    compare_read_beats(4'hE, 16);
    stall_en = 1'b0;
  endtask

  initial begin
    void'($urandom(85025));
    rst_n     = 1'b0;
    s_aw      = '0;
    s_awvalid = 1'b0;
    s_w       = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_ar      = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    m_awready = 1'b0;
    m_wready  = 1'b0;
    m_bresp   = axi_pkg::OKAY;
    m_bvalid  = 1'b0;
    m_arready = 1'b0;
    m_r       = '0;
    m_rvalid  = 1'b0;
    stall_en  = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    reset_values();
    incr_write_burst();
    incr_read_burst();
    wrap_and_fixed_bursts();
    error_resp_merge();
    random_stall_traffic();
    @(negedge clk);
    if (axi_axil_adapter_i.asserts_i.assert_fails == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("a protocol assertion on the lite port failed");
    end
  end

endmodule

// ==== project.f ====
+incdir+.
axi_pkg.sv
axil_pkg.sv
burst_addr_gen.sv
resp_merge.sv
burst_ctrl.sv
axi_axil_adapter.sv
axi_axil_adapter_asserts.sv
axi_axil_adapter_tb.sv
